/* bench/fib_tb.sv */
/*
 * FIB testbench with clock, reset, interest and lookup tasks
 * Reference model of installed prefixes, assertions and a watchdog
 */
`timescale 1ns/100ps

module fib_tb;
    import fib_pkg::*;
    import ndn_pkt_pkg::*;

    localparam int HASH_BITS = 10;
    localparam int CLK_PERIOD = 40;
    localparam int DRIVE_DELAY = 2;
    localparam int NUM_RANDOM = 6;
    localparam int NUM_INTERESTS = 3 + NUM_RANDOM;
    localparam int NUM_LOOKUPS = 5 + NUM_RANDOM;
    localparam int INTEREST_CYCLES = 12;
    // Request, 64 probes of 2 cycles, start, 18 transmit cycles, gap
    localparam int LOOKUP_CYCLES = 2 + 64 * 2 + 2 + 18 + 2;
    localparam int RUN_CYCLES = 8 + NUM_INTERESTS * INTEREST_CYCLES
                                + NUM_LOOKUPS * LOOKUP_CYCLES;

    logic clk;
    logic rst;
    logic rx_valid;
    byte_t data_spi_to_fib;
    logic fib_out_bit;
    prefix_t pit_in_prefix;
    byte_t pit_in_metadata;
    logic prefix_ready;
    prefix_t pit_out_prefix;
    byte_t pit_out_metadata;
    logic fib_to_spi_data_flag;
    byte_t data_fib_to_spi;

    int seed;

    // Reference model of kept names and their lengths
    prefix_t inst_name[$];
    int inst_len[$];

    fib_top #(
        .HASH_BITS (HASH_BITS)
    ) DUT (
        .clk                  (clk),
        .rst                  (rst),
        .rx_valid             (rx_valid),
        .data_spi_to_fib      (data_spi_to_fib),
        .fib_out_bit          (fib_out_bit),
        .pit_in_prefix        (pit_in_prefix),
        .pit_in_metadata      (pit_in_metadata),
        .prefix_ready         (prefix_ready),
        .pit_out_prefix       (pit_out_prefix),
        .pit_out_metadata     (pit_out_metadata),
        .fib_to_spi_data_flag (fib_to_spi_data_flag),
        .data_fib_to_spi      (data_fib_to_spi)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic report_error(string test, logic [63:0] expected, logic [63:0] actual);
        $display("[ERROR] %s: expected %h, actual %h", test, expected, actual);
        $display("tests failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_failure(string what);
        $display("%s", what);
        $display("tests failed");
        $fatal(1, "stopped at first error");
    endtask

    // One clock, then the drive point just after the edge
    task automatic tick();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    // Keep the low len bits of a name
    function automatic prefix_t low_bits(prefix_t name, int len);
        prefix_t kept;
        kept = '0;
        for (int b = 0; b < len; b++) begin
            kept[b] = name[b];
        end
        return kept;
    endfunction

    // Different kept name with the same hash would fake a hit
    function automatic bit hash_clash(prefix_t name, int max_len);
        prefix_t kept;
        for (int l = 1; l <= max_len; l++) begin
            kept = low_bits(name, l);
            for (int i = 0; i < inst_name.size(); i++) begin
                if (inst_len[i] == l && inst_name[i] != kept &&
                    hash_prefix(inst_name[i], HASH_BITS) == hash_prefix(kept, HASH_BITS)) begin
                    return 1'b1;
                end
            end
        end
        return 1'b0;
    endfunction

    // Longest installed prefix of the name up to len, zero if none
    function automatic prefix_t expected_match(prefix_t name, int len);
        for (int l = len; l >= 1; l--) begin
            for (int i = 0; i < inst_name.size(); i++) begin
                if (inst_len[i] == l && inst_name[i] == low_bits(name, l)) begin
                    return inst_name[i];
                end
            end
        end
        return '0;
    endfunction

    function automatic prefix_t random_name();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic int random_range(int lo, int hi);
        return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    // Random flag bits on top, length in bits 5..0
    function automatic byte_t make_meta(int len);
        return byte_t'(($unsigned($random(seed)) & 32'hC0) | len);
    endfunction

    // Name whose search up to max_len meets no false hit
    function automatic prefix_t pick_name(int max_len);
        prefix_t name;
        name = random_name();
        while (hash_clash(name, max_len)) begin
            name = random_name();
        end
        return name;
    endfunction

    // Metadata then 8 name bytes MSB first with prefix_ready 10 cycles after rx_valid
    task automatic send_interest(string test, byte_t meta, prefix_t name);
        rx_valid = 1'b1;
        for (int c = 1; c <= 10; c++) begin
            tick();
            rx_valid = 1'b0;
            if (c == 1) begin
                data_spi_to_fib = meta;
            end else if (c <= 9) begin
                data_spi_to_fib = name[8*(10-c)-1 -: 8];
            end
            assert (prefix_ready == (c == 10))
                else report_error($sformatf("%s prefix_ready cycle %0d", test, c),
                                  64'(c == 10), 64'(prefix_ready));
        end
        assert (pit_out_prefix == name)
            else report_error({test, " pit_out_prefix"}, name, pit_out_prefix);
        assert (pit_out_metadata == meta)
            else report_error({test, " pit_out_metadata"}, 64'(meta), 64'(pit_out_metadata));
        // Install edge has passed after this
        tick();
        inst_name.push_back(low_bits(name, int'(meta[5:0])));
        inst_len.push_back(int'(meta[5:0]));
    endtask

    // Request, wait for the flag, then check the 17 transmitted bytes
    task automatic lookup(string test, prefix_t name, byte_t meta, bit poke_busy);
        logic [8*TX_BYTES-1:0] expected;
        int waited;
        expected = {meta, name, expected_match(name, int'(meta[5:0]))};
        fib_out_bit = 1'b1;
        pit_in_prefix = name;
        pit_in_metadata = meta;
        tick();
        fib_out_bit = 1'b0;
        waited = 0;
        while (!fib_to_spi_data_flag && waited <= LOOKUP_CYCLES) begin
            tick();
            waited++;
        end
        assert (fib_to_spi_data_flag)
            else report_failure($sformatf("%s: no response flag after the lookup request", test));
        for (int i = 0; i < TX_BYTES; i++) begin
            // Extra request in the middle of the transmit
            if (poke_busy) begin
                fib_out_bit = (i == 3);
            end
            tick();
            assert (data_fib_to_spi == expected[8*(TX_BYTES-i)-1 -: 8])
                else report_error($sformatf("%s byte %0d", test, i),
                                  64'(expected[8*(TX_BYTES-i)-1 -: 8]), 64'(data_fib_to_spi));
            assert (!fib_to_spi_data_flag)
                else report_failure($sformatf("%s: second response flag during transmit", test));
        end
        fib_out_bit = 1'b0;
        // Let busy drop before the next request
        tick();
        tick();
    endtask

    prefix_ready_pulse: assert property (
        @(posedge clk) disable iff (rst) prefix_ready |=> !prefix_ready
    ) else report_error("prefix_ready_pulse", 64'd0, 64'd1);

    flag_pulse: assert property (
        @(posedge clk) disable iff (rst) fib_to_spi_data_flag |=> !fib_to_spi_data_flag
    ) else report_error("flag_pulse", 64'd0, 64'd1);

    initial begin
        prefix_t name_a;
        prefix_t name_b;
        prefix_t name_c;
        prefix_t name_r;
        byte_t meta_a;
        int len_a;
        int l1;
        int l2;
        int l3;
        int len_c;
        int len_i;
        int len_q;

        clk = 1'b0;
        rst = 1'b1;
        rx_valid = 1'b0;
        data_spi_to_fib = '0;
        fib_out_bit = 1'b0;
        pit_in_prefix = '0;
        pit_in_metadata = '0;
        seed = 18;

        repeat (2) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;

        // Outputs stay quiet with no stimulus
        for (int i = 0; i < 4; i++) begin
            tick();
            assert (!prefix_ready)
                else report_error("reset_quiet prefix_ready", 64'd0, 64'(prefix_ready));
            assert (!fib_to_spi_data_flag)
                else report_error("reset_quiet flag", 64'd0, 64'(fib_to_spi_data_flag));
        end

        // Exact match on the installed length
        len_a = random_range(16, 63);
        name_a = pick_name(len_a);
        meta_a = make_meta(len_a);
        send_interest("exact_install", meta_a, name_a);
        lookup("exact_match", name_a, meta_a, 1'b0);

        // Same name at two lengths where the longer one wins
        l1 = random_range(8, 23);
        l2 = random_range(24, 47);
        l3 = random_range(48, 63);
        name_b = pick_name(l3);
        send_interest("longest_install_short", make_meta(l1), name_b);
        send_interest("longest_install_long", make_meta(l2), name_b);
        lookup("longest_match", name_b, make_meta(l3), 1'b0);

        // Name with nothing installed
        len_c = random_range(1, 63);
        name_c = random_name();
        while (hash_clash(name_c, len_c) || expected_match(name_c, len_c) != '0) begin
            name_c = random_name();
        end
        lookup("miss", name_c, make_meta(len_c), 1'b0);

        // Request during transmit is dropped and the next one is served
        lookup("busy_ignore", name_a, meta_a, 1'b1);
        lookup("after_busy", name_b, make_meta(l2), 1'b0);

        for (int r = 0; r < NUM_RANDOM; r++) begin
            len_i = random_range(4, 56);
            len_q = random_range(len_i, 63);
            name_r = pick_name(len_q);
            send_interest("random_install", make_meta(len_i), name_r);
            lookup("random_lookup", name_r, make_meta(len_q), 1'b0);
        end

        $display("all tests passed");
        $finish;
    end

    // Bound from packet count and worst case search
    initial begin
        #(2 * RUN_CYCLES * CLK_PERIOD);
        $display("Watchdog expired before the tests completed");
        $display("tests failed");
        $fatal(1, "watchdog timeout");
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the FIB testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module fib_tb -f sources.f -o fib_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/fib_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^all tests passed$" "$LOG"; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1

/* sources.f */
src/fib_pkg.sv
src/ndn_pkt_pkg.sv
src/fib_result_if.sv
src/interest_parser.sv
src/fib_bit_table.sv
src/lpm_lookup.sv
src/fib_tx_serializer.sv
src/fib_top.sv
bench/fib_tb.sv

/* src/fib_bit_table.sv */
/*
 * FIB valid-bit table, one row per prefix length
 * Install port sets bits, probe port returns a registered hit
 */
`timescale 1ns/100ps

module fib_bit_table #(
    parameter int HASH_BITS = 10
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              install_valid,
    input  fib_pkg::prefix_t  install_prefix,
    input  fib_pkg::len_t     install_len,
    input  fib_pkg::prefix_t  probe_prefix,
    input  fib_pkg::len_t     probe_len,
    output logic              hit
);
    import fib_pkg::*;

    // Row holds one valid bit per hash value
    logic [2**HASH_BITS-1:0] rows [TABLE_ROWS];

    logic [MAX_HASH_BITS-1:0] install_hash;
    logic [MAX_HASH_BITS-1:0] probe_hash;

    // Only the kept bits of the name feed the hash
    assign install_hash = hash_prefix(mask_prefix(install_prefix, install_len), HASH_BITS);
    assign probe_hash = hash_prefix(mask_prefix(probe_prefix, probe_len), HASH_BITS);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rows <= '{default: '0};
            hit <= 1'b0;
        end else begin
            if (install_valid) begin
                rows[install_len][install_hash[HASH_BITS-1:0]] <= 1'b1;
            end
            // Probe reads old contents on an install edge
            hit <= rows[probe_len][probe_hash[HASH_BITS-1:0]];
        end
    end

    // Lengths come from parser and lookup unit
    install_len_known: assert property (
        @(posedge clk) disable iff (rst) install_valid |-> !$isunknown(install_len)
    ) else $error("install with unknown prefix length");

    probe_len_known: assert property (
        @(posedge clk) disable iff (rst) !$isunknown(probe_len)
    ) else $error("probe with unknown prefix length");

endmodule

/* src/fib_pkg.sv */
/*
 * FIB table geometry, prefix and length types
 * Fold-XOR prefix hash and prefix length mask functions
 */
package fib_pkg;

    // Name width and prefix length width
    localparam int PREFIX_BITS = 64;
    localparam int LEN_BITS = 6;

    // One valid-bit row per possible prefix length
    localparam int TABLE_ROWS = 2 ** LEN_BITS;

    // Widest hash the table supports
    localparam int MAX_HASH_BITS = 12;

    typedef logic [PREFIX_BITS-1:0] prefix_t;
    typedef logic [LEN_BITS-1:0] len_t;

    // Fold the name into width bits, slices taken upward from bit 0
    // Bits past the end of the last slice count as zero
    function automatic logic [MAX_HASH_BITS-1:0] hash_prefix(prefix_t p, int unsigned width);
        logic [MAX_HASH_BITS-1:0] h;
        h = '0;
        for (int i = 0; i < PREFIX_BITS; i++) begin
            h[i % width] ^= p[i];
        end
        return h;
    endfunction

    // Keep the low len bits of the name, zero the rest
    function automatic prefix_t mask_prefix(prefix_t p, len_t len);
        return p & ((prefix_t'(1) << len) - prefix_t'(1));
    endfunction

endpackage

/* src/fib_result_if.sv */
/*
 * Lookup result channel from search unit to SPI transmitter
 */
`timescale 1ns/100ps

interface fib_result_if;
    import fib_pkg::*;
    import ndn_pkt_pkg::*;

    // One-cycle pulse, result fields valid with it
    logic start;
    byte_t metadata;
    prefix_t full_prefix;
    prefix_t match_prefix;

    // High while the transmitter is sending
    logic busy;

    modport source (
        output start, metadata, full_prefix, match_prefix,
        input busy
    );

    modport sink (
        input start, metadata, full_prefix, match_prefix,
        output busy
    );

endinterface

/* src/fib_top.sv */
/*
 * FIB top level with parser, bit table, LPM search and SPI transmitter
 */
`timescale 1ns/100ps

module fib_top #(
    parameter int HASH_BITS = 10
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rx_valid,
    input  ndn_pkt_pkg::byte_t   data_spi_to_fib,
    input  logic                 fib_out_bit,
    input  fib_pkg::prefix_t     pit_in_prefix,
    input  ndn_pkt_pkg::byte_t   pit_in_metadata,
    output logic                 prefix_ready,
    output fib_pkg::prefix_t     pit_out_prefix,
    output ndn_pkt_pkg::byte_t   pit_out_metadata,
    output logic                 fib_to_spi_data_flag,
    output ndn_pkt_pkg::byte_t   data_fib_to_spi
);
    import fib_pkg::*;

    // Parser to table
    logic install_valid;
    prefix_t install_prefix;
    len_t install_len;

    // Lookup to table and back
    prefix_t probe_prefix;
    len_t probe_len;
    logic hit;

    fib_result_if res_if ();

    interest_parser u_parser (
        .clk              (clk),
        .rst              (rst),
        .rx_valid         (rx_valid),
        .data_spi_to_fib  (data_spi_to_fib),
        .prefix_ready     (prefix_ready),
        .pit_out_prefix   (pit_out_prefix),
        .pit_out_metadata (pit_out_metadata),
        .install_valid    (install_valid),
        .install_prefix   (install_prefix),
        .install_len      (install_len)
    );

    fib_bit_table #(
        .HASH_BITS (HASH_BITS)
    ) u_table (
        .clk            (clk),
        .rst            (rst),
        .install_valid  (install_valid),
        .install_prefix (install_prefix),
        .install_len    (install_len),
        .probe_prefix   (probe_prefix),
        .probe_len      (probe_len),
        .hit            (hit)
    );

    lpm_lookup u_lookup (
        .clk             (clk),
        .rst             (rst),
        .fib_out_bit     (fib_out_bit),
        .pit_in_prefix   (pit_in_prefix),
        .pit_in_metadata (pit_in_metadata),
        .probe_prefix    (probe_prefix),
        .probe_len       (probe_len),
        .hit             (hit),
        .res             (res_if.source)
    );

    fib_tx_serializer u_tx (
        .clk                  (clk),
        .rst                  (rst),
        .res                  (res_if.sink),
        .fib_to_spi_data_flag (fib_to_spi_data_flag),
        .data_fib_to_spi      (data_fib_to_spi)
    );

endmodule

/* src/fib_tx_serializer.sv */
/*
 * SPI transmitter for lookup results
 * Flag pulse, then 17 bytes: metadata, full prefix, matched prefix
 */
`timescale 1ns/100ps

module fib_tx_serializer (
    input  logic                 clk,
    input  logic                 rst,
    fib_result_if.sink           res,
    output logic                 fib_to_spi_data_flag,
    output ndn_pkt_pkg::byte_t   data_fib_to_spi
);
    import ndn_pkt_pkg::*;

    localparam int SR_BITS = 8 * TX_BYTES;
    localparam int CNT_BITS = $clog2(TX_BYTES + 1);

    logic [SR_BITS-1:0] tx_sr;
    logic [CNT_BITS-1:0] byte_cnt;
    logic busy;
    logic load;
    logic shift;

    assign load = res.start && !busy;
    assign shift = busy && (byte_cnt != '0);
    assign res.busy = busy;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fib_to_spi_data_flag <= 1'b0;
            busy <= 1'b0;
            byte_cnt <= '0;
            data_fib_to_spi <= '0;
        end else begin
            fib_to_spi_data_flag <= 1'b0;
            if (load) begin
                fib_to_spi_data_flag <= 1'b1;
                busy <= 1'b1;
                byte_cnt <= CNT_BITS'(TX_BYTES);
            end else if (shift) begin
                data_fib_to_spi <= tx_sr[SR_BITS-1 -: 8];
                byte_cnt <= byte_cnt - 1'b1;
            end else if (busy) begin
                // Last byte is on the line, release
                busy <= 1'b0;
            end
        end
    end

    // MSB-first shift register, metadata leads
    always_ff @(posedge clk) begin
        if (load) begin
            tx_sr <= {res.metadata, res.full_prefix, res.match_prefix};
        end else if (shift) begin
            tx_sr <= tx_sr << 8;
        end
    end

    // Lookup must wait for the previous transmit
    no_start_while_busy: assert property (
        @(posedge clk) disable iff (rst) res.start |-> !busy
    ) else $error("result start while transmitter busy");

endmodule

/* src/interest_parser.sv */
/*
 * Interest parser taking a metadata byte then 8 prefix bytes from SPI
 * Presents the finished interest to the PIT and installs its prefix
 */
`timescale 1ns/100ps

module interest_parser (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rx_valid,
    input  ndn_pkt_pkg::byte_t   data_spi_to_fib,
    output logic                 prefix_ready,
    output fib_pkg::prefix_t     pit_out_prefix,
    output ndn_pkt_pkg::byte_t   pit_out_metadata,
    output logic                 install_valid,
    output fib_pkg::prefix_t     install_prefix,
    output fib_pkg::len_t        install_len
);
    import ndn_pkt_pkg::*;

    localparam int CNT_BITS = $clog2(PREFIX_BYTES);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_META,
        ST_PREFIX
    } state_t;

    state_t state;
    logic [CNT_BITS-1:0] byte_cnt;
    byte_t meta_q;
    // First 7 name bytes while the 8th comes straight from the link
    logic [8*(PREFIX_BYTES-1)-1:0] prefix_sr;

    logic last_byte;

    assign last_byte = (state == ST_PREFIX) && (byte_cnt == '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ST_IDLE;
            byte_cnt <= '0;
            prefix_ready <= 1'b0;
        end else begin
            prefix_ready <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (rx_valid) begin
                        state <= ST_META;
                    end
                end
                ST_META: begin
                    byte_cnt <= CNT_BITS'(PREFIX_BYTES - 1);
                    state <= ST_PREFIX;
                end
                ST_PREFIX: begin
                    byte_cnt <= byte_cnt - 1'b1;
                    // Hand the whole name over on the next cycle
                    if (last_byte) begin
                        prefix_ready <= 1'b1;
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Byte capture and output hold
    always_ff @(posedge clk) begin
        if (state == ST_META) begin
            meta_q <= data_spi_to_fib;
        end
        if (state == ST_PREFIX) begin
            prefix_sr <= {prefix_sr[8*(PREFIX_BYTES-2)-1:0], data_spi_to_fib};
        end
        // Outputs change only when a packet completes
        if (last_byte) begin
            pit_out_prefix <= {prefix_sr, data_spi_to_fib};
            pit_out_metadata <= meta_q;
        end
    end

    // Every parsed interest installs its own prefix
    assign install_valid = prefix_ready;
    assign install_prefix = pit_out_prefix;
    assign install_len = meta_len(pit_out_metadata);

endmodule

/* src/lpm_lookup.sv */
/*
 * Longest prefix match search for PIT lookup requests
 * Probes the table from the requested length downward
 * Hands metadata, full prefix and match to the transmitter
 */
`timescale 1ns/100ps

module lpm_lookup (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 fib_out_bit,
    input  fib_pkg::prefix_t     pit_in_prefix,
    input  ndn_pkt_pkg::byte_t   pit_in_metadata,
    output fib_pkg::prefix_t     probe_prefix,
    output fib_pkg::len_t        probe_len,
    input  logic                 hit,
    fib_result_if.source         res
);
    import fib_pkg::*;
    import ndn_pkt_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_PROBE,
        ST_CHECK,
        ST_DONE
    } state_t;

    state_t state;
    len_t len;
    len_t next_len;
    // Candidate prefix, masked to len
    prefix_t cand;
    logic start_q;
    logic accept;

    // New request only when idle and transmitter free
    assign accept = (state == ST_IDLE) && fib_out_bit && !res.busy;
    assign next_len = len - 1'b1;

    assign probe_prefix = cand;
    assign probe_len = len;
    assign res.start = start_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ST_IDLE;
            len <= '0;
            start_q <= 1'b0;
        end else begin
            start_q <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        len <= meta_len(pit_in_metadata);
                        state <= ST_PROBE;
                    end
                end
                // Table registers hit during this cycle
                ST_PROBE: state <= ST_CHECK;
                ST_CHECK: begin
                    if (hit || len == '0) begin
                        start_q <= 1'b1;
                        state <= ST_DONE;
                    end else begin
                        len <= next_len;
                        state <= ST_PROBE;
                    end
                end
                // Hold results until transmitter takes over
                ST_DONE: begin
                    if (res.busy) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            cand <= mask_prefix(pit_in_prefix, meta_len(pit_in_metadata));
            res.full_prefix <= pit_in_prefix;
            res.metadata <= pit_in_metadata;
        end
        if (state == ST_CHECK) begin
            if (hit) begin
                res.match_prefix <= cand;
            end else if (len == '0) begin
                res.match_prefix <= '0;
            end else begin
                // Drop the top kept bit on a miss
                cand[next_len] <= 1'b0;
            end
        end
    end

    // Search narrows, never widens
    len_never_grows: assert property (
        @(posedge clk) disable iff (rst)
        (state != ST_IDLE && $past(state) != ST_IDLE) |-> (probe_len <= $past(probe_len))
    ) else $error("probe length increased during search");

endmodule

/* src/ndn_pkt_pkg.sv */
/*
 * Interest packet layout on the SPI link
 * Byte type, byte counts and metadata field access
 */
package ndn_pkt_pkg;

    typedef logic [7:0] byte_t;

    // Name is carried as 8 bytes, MSB first
    localparam int PREFIX_BYTES = 8;

    // Metadata, full prefix, matched prefix
    localparam int TX_BYTES = 1 + 2 * PREFIX_BYTES;

    // Prefix length field sits in the low bits of metadata
    localparam int META_LEN_LSB = 0;
    localparam int META_LEN_BITS = 6;

    function automatic logic [META_LEN_BITS-1:0] meta_len(byte_t meta);
        return meta[META_LEN_LSB +: META_LEN_BITS];
    endfunction

endpackage
